// File: all.f
verilog/snakePkg.sv
verilog/gridScanner.sv
verilog/snakeBody.sv
verilog/applePlacer.sv
verilog/collisionDetect.sv
verilog/scoreTracker.sv
verilog/scoreDisplay.sv
verilog/snakeTop.sv
bench/snakeTb.sv

// File: Makefile
TOP := snakeTb
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@./obj_dir/V$(TOP) > $(LOG) 2>&1; st=$$?; cat $(LOG); \
	if grep -q "sim failed" $(LOG); then exit 1; fi; exit $$st

obj_dir/V$(TOP): all.f verilog/*.sv bench/*.sv
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only --timing --assert -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/snakeTb.sv
`timescale 1ns/1ps

module snakeTb;

  localparam int MAX_LENGTH  = 140;
  localparam int DIGIT_DIV   = 64;
  localparam int SCORE_LIMIT = MAX_LENGTH - snakePkg::START_LENGTH;
  localparam int MAX_FRAMES  = 400;
  localparam int OVER_FRAMES = 20;
  localparam int FRAME_LIMIT = 300;

  logic                           hwclk;
  logic                           rstN;
  logic [3:0]                     dirPb;
  logic [snakePkg::GRID_BITS-1:0] cellX;
  logic [snakePkg::GRID_BITS-1:0] cellY;
  logic                           snakeHead;
  logic                           snakeBody;
  logic                           apple;
  logic                           frameSync;
  logic                           gameOver;
  logic [6:0]                     ss0;
  logic [6:0]                     ss1;
  logic [6:0]                     ss2;

  // game model, state as shown in the frame being scanned
  int                             errorCount;
  snakePkg::dirT                  modelHeading;
  logic [snakePkg::GRID_BITS-1:0] modelHeadX;
  logic [snakePkg::GRID_BITS-1:0] modelHeadY;
  int                             modelLength;
  int                             modelScore;
  int                             oldScore;
  bit                             modelOver;
  bit                             growPending;
  // clocks since reset release
  int                             cellTick;
  // last apple cell seen on the scan
  logic [snakePkg::GRID_BITS-1:0] appleX;
  logic [snakePkg::GRID_BITS-1:0] appleY;

  // what one frame of flags showed
  logic [255:0]                   bodyMap;
  logic [255:0]                   frozenMap;
  bit                             frozenValid;
  int                             headCount;
  int                             appleCount;
  logic [snakePkg::GRID_BITS-1:0] seenHeadX;
  logic [snakePkg::GRID_BITS-1:0] seenHeadY;
  bit                             frameGood;
  bit                             frameBad;
  bit                             overSeen;

  snakeTop u_dut (
    .hwclk(hwclk), .rstN(rstN), .dirPb(dirPb), .cellX(cellX), .cellY(cellY),
    .snakeHead(snakeHead), .snakeBody(snakeBody), .apple(apple), .frameSync(frameSync),
    .gameOver(gameOver), .ss0(ss0), .ss1(ss1), .ss2(ss2)
  );

  initial begin
    hwclk = 1'b0;
    forever #4 hwclk = ~hwclk;
  end

  task automatic compare(input logic [255:0] got, input logic [255:0] expected,
                         input string msg);
    if (got !== expected) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s (got %0h, expected %0h)", $time, msg, got, expected);
    end
  endtask

  // wall ring around the playing field
  function automatic bit isBorder(input logic [3:0] x, input logic [3:0] y);
    return (x == 4'd0) || (x == 4'd15) || (y == 4'd0) || (y == 4'd15);
  endfunction

  // a in bit 0 up to g in bit 6
  function automatic logic [6:0] sevenSeg(input logic [3:0] digit);
    logic [6:0] table10 [10];
    table10 = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07, 7'h7F, 7'h6F};
    return table10[digit];
  endfunction

  function automatic snakePkg::dirT opposite(input snakePkg::dirT d);
    case (d)
      snakePkg::dirUp:   return snakePkg::dirDown;
      snakePkg::dirDown: return snakePkg::dirUp;
      snakePkg::dirLeft: return snakePkg::dirRight;
      default:           return snakePkg::dirLeft;
    endcase
  endfunction

  // one press exactly, never straight back
  function automatic snakePkg::dirT turnFor(input snakePkg::dirT cur, input logic [3:0] pb);
    snakePkg::dirT want;
    if ($countones(pb) != 1) return cur;
    if (pb[3]) want = snakePkg::dirUp;
    else if (pb[2]) want = snakePkg::dirDown;
    else if (pb[1]) want = snakePkg::dirLeft;
    else want = snakePkg::dirRight;
    return (want == opposite(cur)) ? cur : want;
  endfunction

  // mostly chase the apple, sometimes any button mix
  function automatic logic [3:0] pickButtons();
    if (($urandom % 4) == 0) return 4'($urandom % 16);
    if (appleX > modelHeadX) return 4'b0001;
    if (appleX < modelHeadX) return 4'b0010;
    if (appleY > modelHeadY) return 4'b0100;
    return 4'b1000;
  endfunction

  // score changes after cell (0,0), so that cell still shows the old one
  task automatic checkDisplay(input int shown);
    logic [2:0][3:0] digit;
    logic [2:0][6:0] segs;
    int              sel;
    digit[0] = 4'(shown % 10);
    digit[1] = 4'((shown / 10) % 10);
    digit[2] = 4'((shown / 100) % 10);
    segs = {ss2, ss1, ss0};
    // digit select steps every DIGIT_DIV clocks, ones first
    sel = (cellTick / DIGIT_DIV) % 3;
    for (int i = 0; i < 3; i++) begin
      if (i == sel) begin
        compare(segs[i], sevenSeg(digit[i]), $sformatf("segments of digit %0d", i));
      end else begin
        compare(segs[i], 7'h00, $sformatf("blank digit %0d", i));
      end
    end
  endtask

  task automatic sampleCell();
    if (snakeHead) begin
      headCount++;
      seenHeadX = cellX;
      seenHeadY = cellY;
      if (isBorder(cellX, cellY) || snakeBody) frameBad = 1'b1;
      if (apple) frameGood = 1'b1;
    end
    if (snakeBody) bodyMap[{cellX, cellY}] = 1'b1;
    if (apple) begin
      appleCount++;
      appleX = cellX;
      appleY = cellY;
      compare(isBorder(cellX, cellY), 0, "apple on a border cell");
      compare(snakeBody, 0, "apple on a body cell");
    end
    checkDisplay(((cellX == 4'd0) && (cellY == 4'd0)) ? oldScore : modelScore);
    cellTick++;
  endtask

  // sample every cell at the falling edge up to and including the frameSync cell
  task automatic scanFrame(output bit timedOut);
    int cycles;
    bit lastCell;
    cycles = 0;
    lastCell = 1'b0;
    timedOut = 1'b0;
    headCount = 0;
    appleCount = 0;
    bodyMap = '0;
    frameGood = 1'b0;
    frameBad = 1'b0;
    while (!lastCell && !timedOut) begin
      // raster position follows the cell count
      compare(cellX, cycles % 16, "scan column");
      compare(cellY, cycles / 16, "scan row");
      compare(frameSync, cycles == 255, "frameSync on the last cell");
      sampleCell();
      lastCell = frameSync;
      if (lastCell) begin
        overSeen = gameOver;
      end else begin
        cycles++;
        if (cycles >= FRAME_LIMIT) begin
          timedOut = 1'b1;
          errorCount++;
          $display("ERROR: no frameSync within %0d cycles at %0t", FRAME_LIMIT, $time);
        end else begin
          @(negedge hwclk);
        end
      end
    end
  endtask

  task automatic checkFrame(input int frameIndex);
    compare(headCount, 1, "head cells in frame");
    compare(seenHeadX, modelHeadX, "head column");
    compare(seenHeadY, modelHeadY, "head row");
    compare(overSeen, modelOver, "gameOver at end of frame");
    if (appleCount > 1) compare(appleCount, 1, "apple cells in frame");
    if (modelOver) begin
      // body stops moving once the game is over
      if (frozenValid) compare(bodyMap, frozenMap, "body after game over");
      frozenMap = bodyMap;
      frozenValid = 1'b1;
    end else begin
      compare($countones(bodyMap), modelLength - 1, "body cell count");
    end
    if (frameIndex == 0) begin
      compare(bodyMap[{4'd7, 4'd8}], 1, "start body cell (7,8)");
      compare(bodyMap[{4'd6, 4'd8}], 1, "start body cell (6,8)");
      compare(appleCount, 1, "apple shown after reset");
      compare({appleX, appleY}, {snakePkg::START_APPLE_X, snakePkg::START_APPLE_Y},
              "start apple cell");
    end
  endtask

  // move on frameSync, then fold in this frame's hits
  task automatic updateModel();
    if (!modelOver) begin
      modelHeading = turnFor(modelHeading, dirPb);
      case (modelHeading)
        snakePkg::dirUp:   modelHeadY = modelHeadY - 4'd1;
        snakePkg::dirDown: modelHeadY = modelHeadY + 4'd1;
        snakePkg::dirLeft: modelHeadX = modelHeadX - 4'd1;
        default:           modelHeadX = modelHeadX + 4'd1;
      endcase
      if (growPending) modelLength++;
      growPending = 1'b0;
    end
    oldScore = modelScore;
    if (!modelOver) begin
      if (frameBad) begin
        modelOver = 1'b1;
      end else if (frameGood) begin
        modelScore++;
        growPending = 1'b1;
        if (modelScore == SCORE_LIMIT) modelOver = 1'b1;
      end
    end
  endtask

  initial begin
    bit timedOut;
    bit done;
    int frameCount;
    int overFrames;
    void'($urandom(32'h956d));
    rstN = 1'b0;
    dirPb = 4'b0000;
    errorCount = 0;
    modelHeading = snakePkg::dirRight;
    modelHeadX = snakePkg::START_HEAD_X;
    modelHeadY = snakePkg::START_HEAD_Y;
    modelLength = snakePkg::START_LENGTH;
    modelScore = 0;
    oldScore = 0;
    modelOver = 1'b0;
    growPending = 1'b0;
    cellTick = 0;
    appleX = snakePkg::START_APPLE_X;
    appleY = snakePkg::START_APPLE_Y;
    frozenValid = 1'b0;
    timedOut = 1'b0;
    done = 1'b0;
    frameCount = 0;
    overFrames = 0;
    repeat (2) @(negedge hwclk);
    rstN = 1'b1;
    // each pass starts on the falling edge of cell (0,0)
    while (!done) begin
      dirPb = pickButtons();
      scanFrame(timedOut);
      if (timedOut) begin
        done = 1'b1;
      end else begin
        checkFrame(frameCount);
        updateModel();
        frameCount++;
        if (modelOver) overFrames++;
        if ((frameCount >= MAX_FRAMES) || (overFrames >= OVER_FRAMES)) done = 1'b1;
        else @(negedge hwclk);
      end
    end
    $display("%0d errors in %0d frames, score %0d", errorCount, frameCount, modelScore);
    if (errorCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: verilog/snakeTop.sv
`timescale 1ns/1ps

module snakeTop #(
  parameter int MAX_LENGTH = 140,
  parameter int DIGIT_DIV  = 64
) (
  input  logic                           hwclk,
  input  logic                           rstN,
  input  logic [3:0]                     dirPb,
  output logic [snakePkg::GRID_BITS-1:0] cellX,
  output logic [snakePkg::GRID_BITS-1:0] cellY,
  output logic                           snakeHead,
  output logic                           snakeBody,
  output logic                           apple,
  output logic                           frameSync,
  output logic                           gameOver,
  output logic [6:0]                     ss0,
  output logic [6:0]                     ss1,
  output logic [6:0]                     ss2
);

  logic                          goodColl;
  logic                          badColl;
  logic [MAX_LENGTH-1:0][7:0]    body;
  logic [7:0]                    snakeLength;
  logic [3:0]                    bcdOnes;
  logic [3:0]                    bcdTens;
  logic [3:0]                    bcdHundreds;

  // raster over the grid
  gridScanner uScanner(.hwclk(hwclk), .rstN(rstN), .cellX(cellX), .cellY(cellY),
                       .frameSync(frameSync));

  // head, body and apple flags for the scanned cell
  snakeBody #(.MAX_LENGTH(MAX_LENGTH)) uBody(.hwclk(hwclk), .rstN(rstN), .dirPb(dirPb),
    .cellX(cellX), .cellY(cellY), .frameSync(frameSync), .goodColl(goodColl),
    .gameOver(gameOver), .snakeHead(snakeHead), .snakeBody(snakeBody), .body(body),
    .snakeLength(snakeLength));
  applePlacer #(.MAX_LENGTH(MAX_LENGTH)) uApple(.hwclk(hwclk), .rstN(rstN), .cellX(cellX),
    .cellY(cellY), .goodColl(goodColl), .body(body), .snakeLength(snakeLength),
    .apple(apple));

  // per-frame hit report
  collisionDetect uCollision(.hwclk(hwclk), .rstN(rstN), .cellX(cellX), .cellY(cellY),
    .frameSync(frameSync), .snakeHead(snakeHead), .snakeBody(snakeBody), .apple(apple),
    .goodColl(goodColl), .badColl(badColl));

  // score and seven-segment output
  scoreTracker #(.MAX_LENGTH(MAX_LENGTH)) uScore(.hwclk(hwclk), .rstN(rstN),
    .goodColl(goodColl), .badColl(badColl), .bcdOnes(bcdOnes), .bcdTens(bcdTens),
    .bcdHundreds(bcdHundreds), .gameOver(gameOver));
  scoreDisplay #(.DIGIT_DIV(DIGIT_DIV)) uDisplay(.hwclk(hwclk), .rstN(rstN),
    .bcdOnes(bcdOnes), .bcdTens(bcdTens), .bcdHundreds(bcdHundreds), .ss0(ss0),
    .ss1(ss1), .ss2(ss2));

endmodule

// File: verilog/scoreDisplay.sv
`timescale 1ns/1ps

module scoreDisplay #(
  parameter int DIGIT_DIV = 64
) (
  input  logic       hwclk,
  input  logic       rstN,
  input  logic [3:0] bcdOnes,
  input  logic [3:0] bcdTens,
  input  logic [3:0] bcdHundreds,
  output logic [6:0] ss0,
  output logic [6:0] ss1,
  output logic [6:0] ss2
);

  localparam int DIV_BITS = $clog2(DIGIT_DIV + 1);

  logic [DIV_BITS-1:0] divCount;
  // 0 ones, 1 tens, 2 hundreds
  logic [1:0]          digitSel;

  // segment a in bit 0 up to g in bit 6, lit when high
  function automatic logic [6:0] segCode(input logic [3:0] digit);
    case (digit)
      4'd0:    return 7'h3F;
      4'd1:    return 7'h06;
      4'd2:    return 7'h5B;
      4'd3:    return 7'h4F;
      4'd4:    return 7'h66;
      4'd5:    return 7'h6D;
      4'd6:    return 7'h7D;
      4'd7:    return 7'h07;
      4'd8:    return 7'h7F;
      4'd9:    return 7'h6F;
      default: return 7'h00;
    endcase
  endfunction

  // next digit every DIGIT_DIV clocks
  always_ff @(posedge hwclk or negedge rstN) begin
    if (!rstN) begin
      divCount <= '0;
      digitSel <= '0;
    end else if (divCount == DIV_BITS'(DIGIT_DIV - 1)) begin
      divCount <= '0;
      digitSel <= (digitSel == 2'd2) ? 2'd0 : digitSel + 2'd1;
    end else begin
      divCount <= divCount + 1'b1;
    end
  end

  // only the selected digit lights up
  assign ss0 = (digitSel == 2'd0) ? segCode(bcdOnes) : 7'h00;
  assign ss1 = (digitSel == 2'd1) ? segCode(bcdTens) : 7'h00;
  assign ss2 = (digitSel == 2'd2) ? segCode(bcdHundreds) : 7'h00;

endmodule

// File: verilog/scoreTracker.sv
`timescale 1ns/1ps

module scoreTracker #(
  parameter int MAX_LENGTH = 140
) (
  input  logic       hwclk,
  input  logic       rstN,
  input  logic       goodColl,
  input  logic       badColl,
  output logic [3:0] bcdOnes,
  output logic [3:0] bcdTens,
  output logic [3:0] bcdHundreds,
  output logic       gameOver
);

  typedef enum logic {
    playing,
    over
  } gameStateT;

  // full snake means the game is won
  localparam logic [7:0] SCORE_LIMIT = 8'(MAX_LENGTH - snakePkg::START_LENGTH);

  gameStateT  state;
  logic [7:0] scoreCount;

  always_ff @(posedge hwclk or negedge rstN) begin
    if (!rstN) begin
      state       <= playing;
      scoreCount  <= '0;
      bcdOnes     <= '0;
      bcdTens     <= '0;
      bcdHundreds <= '0;
    end else if (state == playing) begin
      if (badColl || (scoreCount == SCORE_LIMIT)) begin
        state <= over;
      end else if (goodColl) begin
        scoreCount <= scoreCount + 8'd1;
        // ripple the carry through the digits
        if (bcdOnes == 4'd9) begin
          bcdOnes <= '0;
          if (bcdTens == 4'd9) begin
            bcdTens     <= '0;
            bcdHundreds <= (bcdHundreds == 4'd9) ? 4'd0 : bcdHundreds + 4'd1;
          end else begin
            bcdTens <= bcdTens + 4'd1;
          end
        end else begin
          bcdOnes <= bcdOnes + 4'd1;
        end
      end
    end
  end

  // over is terminal until reset
  assign gameOver = (state == over);

endmodule

// File: verilog/collisionDetect.sv
`timescale 1ns/1ps

module collisionDetect (
  input  logic                           hwclk,
  input  logic                           rstN,
  input  logic [snakePkg::GRID_BITS-1:0] cellX,
  input  logic [snakePkg::GRID_BITS-1:0] cellY,
  input  logic                           frameSync,
  input  logic                           snakeHead,
  input  logic                           snakeBody,
  input  logic                           apple,
  output logic                           goodColl,
  output logic                           badColl
);

  logic border;
  logic goodNow;
  logic badNow;
  logic goodHit;
  logic badHit;

  assign border = snakePkg::onBorder(cellX, cellY);

  // hits seen on the cell being scanned
  assign goodNow = snakeHead && apple;
  assign badNow  = snakeHead && (border || snakeBody);

  always_ff @(posedge hwclk or negedge rstN) begin
    if (!rstN) begin
      goodHit  <= 1'b0;
      badHit   <= 1'b0;
      goodColl <= 1'b0;
      badColl  <= 1'b0;
    end else if (frameSync) begin
      // last cell folded in here, then report once
      // a crash wins over an apple
      badColl  <= badHit || badNow;
      goodColl <= (goodHit || goodNow) && !(badHit || badNow);
      goodHit  <= 1'b0;
      badHit   <= 1'b0;
    end else begin
      goodColl <= 1'b0;
      badColl  <= 1'b0;
      goodHit  <= goodHit || goodNow;
      badHit   <= badHit || badNow;
    end
  end

  // exclusive pulses
  collExclusive: assert property (@(posedge hwclk) disable iff (!rstN)
    !(goodColl && badColl));

endmodule

// File: verilog/applePlacer.sv
`timescale 1ns/1ps

module applePlacer #(
  parameter int MAX_LENGTH = 140
) (
  input  logic                           hwclk,
  input  logic                           rstN,
  input  logic [snakePkg::GRID_BITS-1:0] cellX,
  input  logic [snakePkg::GRID_BITS-1:0] cellY,
  input  logic                           goodColl,
  input  logic [MAX_LENGTH-1:0][7:0]     body,
  input  logic [7:0]                     snakeLength,
  output logic                           apple
);

  typedef enum logic {
    placed,
    searching
  } appleStateT;

  appleStateT state;
  logic [7:0] lfsr;
  logic [7:0] appleCell;
  logic       candidateFree;

  // free running, taps 8 6 5 4, never all zero
  always_ff @(posedge hwclk or negedge rstN) begin
    if (!rstN) begin
      lfsr <= 8'hA5;
    end else begin
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    end
  end

  // lfsr word read as {x, y}
  always_comb begin
    candidateFree = !snakePkg::onBorder(lfsr[7:4], lfsr[3:0]);
    for (int i = 0; i < MAX_LENGTH; i++) begin
      if ((i < snakeLength) && (body[i] == lfsr)) begin
        candidateFree = 1'b0;
      end
    end
  end

  always_ff @(posedge hwclk or negedge rstN) begin
    if (!rstN) begin
      state     <= placed;
      appleCell <= {snakePkg::START_APPLE_X, snakePkg::START_APPLE_Y};
    end else begin
      case (state)
        // eaten, hide and start drawing candidates
        placed: if (goodColl) state <= searching;
        // one candidate per clock until a free cell turns up
        searching: begin
          if (candidateFree) begin
            appleCell <= lfsr;
            state     <= placed;
          end
        end
        default: state <= placed;
      endcase
    end
  end

  assign apple = (state == placed) && (appleCell == {cellX, cellY});

  // border cells can never carry the apple
  appleOffBorder: assert property (@(posedge hwclk) disable iff (!rstN)
    (state == placed) |-> !snakePkg::onBorder(appleCell[7:4], appleCell[3:0]));

endmodule

// File: verilog/snakeBody.sv
`timescale 1ns/1ps

module snakeBody #(
  parameter int MAX_LENGTH = 140
) (
  input  logic                           hwclk,
  input  logic                           rstN,
  // up, down, left, right from msb to lsb
  input  logic [3:0]                     dirPb,
  input  logic [snakePkg::GRID_BITS-1:0] cellX,
  input  logic [snakePkg::GRID_BITS-1:0] cellY,
  input  logic                           frameSync,
  input  logic                           goodColl,
  input  logic                           gameOver,
  output logic                           snakeHead,
  output logic                           snakeBody,
  output logic [MAX_LENGTH-1:0][7:0]     body,
  output logic [7:0]                     snakeLength
);

  snakePkg::dirT                  heading;
  snakePkg::dirT                  nextHeading;
  logic                           growPending;
  logic [snakePkg::GRID_BITS-1:0] headX;
  logic [snakePkg::GRID_BITS-1:0] headY;
  logic [snakePkg::GRID_BITS-1:0] nextX;
  logic [snakePkg::GRID_BITS-1:0] nextY;
  logic [7:0]                     scanCell;

  // cells are packed as {x, y}, head sits in slot 0
  assign headX    = body[0][7:4];
  assign headY    = body[0][3:0];
  assign scanCell = {cellX, cellY};

  // single press only, no turning back onto the neck
  always_comb begin
    nextHeading = heading;
    case (dirPb)
      4'b1000: if (heading != snakePkg::dirDown) nextHeading = snakePkg::dirUp;
      4'b0100: if (heading != snakePkg::dirUp) nextHeading = snakePkg::dirDown;
      4'b0010: if (heading != snakePkg::dirRight) nextHeading = snakePkg::dirLeft;
      4'b0001: if (heading != snakePkg::dirLeft) nextHeading = snakePkg::dirRight;
      default: nextHeading = heading;
    endcase
  end

  // head one step along the new heading, y grows downwards
  always_comb begin
    nextX = headX;
    nextY = headY;
    case (nextHeading)
      snakePkg::dirUp:    nextY = headY - 1'b1;
      snakePkg::dirDown:  nextY = headY + 1'b1;
      snakePkg::dirLeft:  nextX = headX - 1'b1;
      snakePkg::dirRight: nextX = headX + 1'b1;
      default:            nextX = headX;
    endcase
  end

  always_ff @(posedge hwclk or negedge rstN) begin
    if (!rstN) begin
      heading     <= snakePkg::dirRight;
      growPending <= 1'b0;
      snakeLength <= 8'(snakePkg::START_LENGTH);
      // straight line to the left of the start head
      for (int i = 0; i < MAX_LENGTH; i++) begin
        if (i < snakePkg::START_LENGTH) begin
          body[i] <= {snakePkg::START_HEAD_X - i[snakePkg::GRID_BITS-1:0],
                      snakePkg::START_HEAD_Y};
        end else begin
          body[i] <= '0;
        end
      end
    end else begin
      // apple eaten last frame, keep the tail on the next move
      if (goodColl) begin
        growPending <= 1'b1;
      end
      if (frameSync && !gameOver) begin
        heading <= nextHeading;
        // shift every slot towards the tail, slots past the length are don't care
        body    <= {body[MAX_LENGTH-2:0], nextX, nextY};
        if (growPending && (snakeLength < MAX_LENGTH)) begin
          snakeLength <= snakeLength + 8'd1;
        end
        growPending <= 1'b0;
      end
    end
  end

  assign snakeHead = (body[0] == scanCell);

  // live slots only, head excluded
  always_comb begin
    snakeBody = 1'b0;
    for (int i = 1; i < MAX_LENGTH; i++) begin
      if ((i < snakeLength) && (body[i] == scanCell)) begin
        snakeBody = 1'b1;
      end
    end
  end

  // array bound is never overrun
  lengthBound: assert property (@(posedge hwclk) disable iff (!rstN)
    snakeLength <= MAX_LENGTH);

endmodule

// File: verilog/gridScanner.sv
`timescale 1ns/1ps

module gridScanner (
  input  logic                           hwclk,
  input  logic                           rstN,
  output logic [snakePkg::GRID_BITS-1:0] cellX,
  output logic [snakePkg::GRID_BITS-1:0] cellY,
  output logic                           frameSync
);

  // last column and last row of the raster
  logic lastX;
  logic lastY;

  assign lastX = (cellX == '1);
  assign lastY = (cellY == '1);

  // one cell per clock, row by row
  always_ff @(posedge hwclk or negedge rstN) begin
    if (!rstN) begin
      cellX <= '0;
      cellY <= '0;
    end else begin
      // x wraps by itself at 15
      cellX <= cellX + 1'b1;
      // next row once the column wraps
      if (lastX) begin
        cellY <= cellY + 1'b1;
      end
    end
  end

  // high only while cell (15,15) is on the scan
  // frame boundary for every block downstream
  assign frameSync = lastX && lastY;

endmodule

// File: verilog/snakePkg.sv
package snakePkg;

  // heading of the snake, one per push button
  typedef enum logic [1:0] {
    dirUp,
    dirDown,
    dirLeft,
    dirRight
  } dirT;

  // bits per grid coordinate, 16 by 16 cells
  localparam int GRID_BITS = 4;

  // length right after reset, head included
  localparam int START_LENGTH = 3;

  // reset cells
  localparam logic [GRID_BITS-1:0] START_HEAD_X = 4'd8;
  localparam logic [GRID_BITS-1:0] START_HEAD_Y = 4'd8;
  localparam logic [GRID_BITS-1:0] START_APPLE_X = 4'd12;
  localparam logic [GRID_BITS-1:0] START_APPLE_Y = 4'd4;

  // outer ring of the grid is the wall
  function automatic logic onBorder(input logic [GRID_BITS-1:0] x,
                                    input logic [GRID_BITS-1:0] y);
    return (x == '0) || (x == '1) || (y == '0) || (y == '1);
  endfunction

endpackage
